// File: source/rvv_mask_params.svh
`ifndef RVV_MASK_PARAMS_SVH
`define RVV_MASK_PARAMS_SVH

// vector register length in bits
`define VLEN 64

// vl reaches VLEN, so one extra bit
`define VL_WIDTH ($clog2(`VLEN) + 1)

// vstart indexes an element below VLEN
`define VSTART_WIDTH $clog2(`VLEN)

`endif

// File: source/rvv_mask_op_pkg.sv
`default_nettype none

package rvv_mask_op_pkg;

  typedef logic [5:0] funct6_t;
  typedef logic [2:0] funct3_t;
  typedef logic [4:0] vs1_code_t;

  localparam funct3_t OPMVV = 3'b010;

  // mask-logical funct6
  localparam funct6_t VMANDN    = 6'b011000;
  localparam funct6_t VMAND     = 6'b011001;
  localparam funct6_t VMOR      = 6'b011010;
  localparam funct6_t VMXOR     = 6'b011011;
  localparam funct6_t VMORN     = 6'b011100;
  localparam funct6_t VMNAND    = 6'b011101;
  localparam funct6_t VMNOR     = 6'b011110;
  localparam funct6_t VMXNOR    = 6'b011111;
  // in the unary groups vs1 selects the operation
  localparam funct6_t VWXUNARY0 = 6'b010000;
  localparam funct6_t VMUNARY0  = 6'b010100;

  localparam vs1_code_t VCPOP  = 5'b10000;
  localparam vs1_code_t VFIRST = 5'b10001;
  localparam vs1_code_t VMSBF  = 5'b00001;
  localparam vs1_code_t VMSOF  = 5'b00010;
  localparam vs1_code_t VMSIF  = 5'b00011;

  typedef enum logic [3:0] {
    MOP_NONE, MOP_ANDN, MOP_AND, MOP_OR,
    MOP_XOR, MOP_ORN, MOP_NAND, MOP_NOR,
    MOP_XNOR, MOP_MSBF, MOP_MSIF, MOP_MSOF,
    MOP_FIRST, MOP_CPOP
  } mask_op_e;

endpackage

`default_nettype wire

// File: source/rvv_mask_data_pkg.sv
`default_nettype none

`include "rvv_mask_params.svh"

package rvv_mask_data_pkg;

  // one vector register, also used for masks
  typedef logic [`VLEN-1:0] vreg_t;

  // vector length
  typedef logic [`VL_WIDTH-1:0] vl_t;

  // start element
  typedef logic [`VSTART_WIDTH-1:0] vstart_t;

endpackage

`default_nettype wire

// File: source/mask_uop_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_params.svh"

module mask_uop_decode (
  input  logic                         uop_valid,
  input  rvv_mask_op_pkg::funct6_t     funct6,
  input  rvv_mask_op_pkg::funct3_t     funct3,
  input  rvv_mask_op_pkg::vs1_code_t   vs1_code,
  input  logic                         vm,
  input  rvv_mask_data_pkg::vl_t       vl,
  input  rvv_mask_data_pkg::vstart_t   vstart,
  input  rvv_mask_data_pkg::vreg_t     v0_data,
  input  rvv_mask_data_pkg::vreg_t     vs1_data,
  input  rvv_mask_data_pkg::vreg_t     vs2_data,
  input  logic                         v0_data_valid,
  input  logic                         vs1_data_valid,
  input  logic                         vs2_data_valid,
  input  logic                         vd_data_valid,
  output rvv_mask_op_pkg::mask_op_e    op,
  output logic                         op_valid,
  output rvv_mask_data_pkg::vreg_t     src1,
  output rvv_mask_data_pkg::vreg_t     src2,
  output rvv_mask_data_pkg::vreg_t     keep_mask
);

  import rvv_mask_op_pkg::*;
  import rvv_mask_data_pkg::*;

  mask_op_e dec_op;
  logic     unary_ready;
  logic     ready;
  vreg_t    tail_mask;
  vreg_t    vstart_onehot;
  vreg_t    prefix_mask;

  always_comb begin
    dec_op = MOP_NONE;
    if (funct3 == OPMVV) begin
      case (funct6)
        VMANDN: dec_op = MOP_ANDN;
        VMAND:  dec_op = MOP_AND;
        VMOR:   dec_op = MOP_OR;
        VMXOR:  dec_op = MOP_XOR;
        VMORN:  dec_op = MOP_ORN;
        VMNAND: dec_op = MOP_NAND;
        VMNOR:  dec_op = MOP_NOR;
        VMXNOR: dec_op = MOP_XNOR;
        VWXUNARY0: begin
          if (vs1_code == VCPOP)
            dec_op = MOP_CPOP;
          else if (vs1_code == VFIRST)
            dec_op = MOP_FIRST;
        end
        VMUNARY0: begin
          if (vs1_code == VMSBF)
            dec_op = MOP_MSBF;
          else if (vs1_code == VMSIF)
            dec_op = MOP_MSIF;
          else if (vs1_code == VMSOF)
            dec_op = MOP_MSOF;
        end
        default: dec_op = MOP_NONE;
      endcase
    end
  end

  // unary forms read vs2 only, v0 when masked
  assign unary_ready = !vs1_data_valid && vs2_data_valid && (vm || v0_data_valid);

  always_comb begin
    case (dec_op)
      MOP_ANDN, MOP_AND, MOP_OR, MOP_XOR,
      MOP_ORN, MOP_NAND, MOP_NOR, MOP_XNOR:
        ready = vs1_data_valid && vs2_data_valid && vd_data_valid && vm;
      MOP_FIRST, MOP_CPOP:
        ready = unary_ready;
      MOP_MSBF, MOP_MSIF, MOP_MSOF:
        ready = unary_ready && (vm || vd_data_valid);
      default:
        ready = 1'b0;
    endcase
  end

  assign op_valid = uop_valid && ready;
  assign op       = op_valid ? dec_op : MOP_NONE;

  always_comb begin
    for (int i = 0; i < `VLEN; i++) begin
      tail_mask[i] = vl_t'(i) < vl;
    end
  end

  // elements below vstart
  assign vstart_onehot = vreg_t'(1) << vstart;
  assign prefix_mask   = vstart_onehot - vreg_t'(1);

  always_comb begin
    src1      = '0;
    src2      = '0;
    keep_mask = '0;
    case (dec_op)
      MOP_ANDN, MOP_AND, MOP_OR, MOP_XOR,
      MOP_ORN, MOP_NAND, MOP_NOR, MOP_XNOR: begin
        src1      = vs1_data;
        src2      = vs2_data;
        keep_mask = prefix_mask;
      end
      MOP_FIRST, MOP_CPOP: begin
        src2 = vm ? (vs2_data & tail_mask) : (vs2_data & tail_mask & v0_data);
      end
      MOP_MSBF, MOP_MSIF, MOP_MSOF: begin
        src2      = vm ? vs2_data : (vs2_data & v0_data);
        // masked-off elements keep vd
        keep_mask = vm ? '0 : ~v0_data;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/mask_logic_ops.sv
`timescale 1ns/1ps
`default_nettype none

module mask_logic_ops (
  input  rvv_mask_op_pkg::mask_op_e   op,
  input  rvv_mask_data_pkg::vreg_t    src1,
  input  rvv_mask_data_pkg::vreg_t    src2,
  output rvv_mask_data_pkg::vreg_t    logic_result
);

  import rvv_mask_op_pkg::*;

  always_comb begin
    case (op)
      MOP_ANDN: logic_result = src2 & ~src1;
      MOP_AND:  logic_result = src2 & src1;
      MOP_OR:   logic_result = src2 | src1;
      MOP_XOR:  logic_result = src2 ^ src1;
      MOP_ORN:  logic_result = src2 | ~src1;
      // inverted outputs
      MOP_NAND: logic_result = ~(src2 & src1);
      MOP_NOR:  logic_result = ~(src2 | src1);
      MOP_XNOR: logic_result = ~(src2 ^ src1);
      default:  logic_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/mask_set_first.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_params.svh"

module mask_set_first (
  input  rvv_mask_op_pkg::mask_op_e   op,
  input  rvv_mask_data_pkg::vreg_t    src2,
  output rvv_mask_data_pkg::vreg_t    first_result
);

  import rvv_mask_op_pkg::*;
  import rvv_mask_data_pkg::*;

  vreg_t   src2_sub1;
  vreg_t   only_first;
  vreg_t   upto_first;
  vreg_t   incl_first;
  vreg_t   before_first;
  logic    src_zero;
  vstart_t first_idx;

  assign src2_sub1 = src2 - vreg_t'(1);
  assign src_zero  = (src2 == '0);

  // subtracting one flips the lowest set bit and everything under it
  assign only_first   = src2 & ~src2_sub1;
  assign upto_first   = src2 ^ src2_sub1;
  assign incl_first   = src_zero ? '1 : upto_first;
  assign before_first = src_zero ? '1 : {1'b0, upto_first[`VLEN-1:1]};

  // scan downward so the lowest set bit wins
  always_comb begin
    first_idx = '0;
    for (int i = `VLEN - 1; i >= 0; i--) begin
      if (src2[i])
        first_idx = vstart_t'(i);
    end
  end

  always_comb begin
    case (op)
      MOP_MSBF:  first_result = before_first;
      MOP_MSIF:  first_result = incl_first;
      // no set bit leaves vmsof all zero
      MOP_MSOF:  first_result = only_first;
      MOP_FIRST: first_result = src_zero ? '1 : vreg_t'(first_idx);
      default:   first_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/mask_popcount.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvv_mask_params.svh"

module mask_popcount (
  input  rvv_mask_data_pkg::vreg_t    src2,
  output rvv_mask_data_pkg::vreg_t    pop_count
);

  import rvv_mask_data_pkg::*;

  // heap-ordered tree with leaves from VLEN up and the root at 1
  vl_t node [1:2*`VLEN-1];

  always_comb begin
    for (int i = 0; i < `VLEN; i++) begin
      node[`VLEN + i] = vl_t'(src2[i]);
    end
    for (int i = `VLEN - 1; i >= 1; i--) begin
      node[i] = node[2*i] + node[2*i + 1];
    end
  end

  assign pop_count = vreg_t'(node[1]);

endmodule

`default_nettype wire

// File: source/mask_result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module mask_result_merge (
  input  logic                        clk,
  input  logic                        arst_n,
  input  rvv_mask_op_pkg::mask_op_e   op,
  input  logic                        op_valid,
  input  rvv_mask_data_pkg::vreg_t    keep_mask,
  input  rvv_mask_data_pkg::vreg_t    vd_data,
  input  rvv_mask_data_pkg::vreg_t    logic_result,
  input  rvv_mask_data_pkg::vreg_t    first_result,
  input  rvv_mask_data_pkg::vreg_t    pop_count,
  output logic                        result_valid,
  output rvv_mask_data_pkg::vreg_t    result_data
);

  import rvv_mask_op_pkg::*;
  import rvv_mask_data_pkg::*;

  vreg_t sel_result;
  vreg_t merged;

  always_comb begin
    case (op)
      MOP_ANDN, MOP_AND, MOP_OR, MOP_XOR,
      MOP_ORN, MOP_NAND, MOP_NOR, MOP_XNOR:
        sel_result = logic_result;
      MOP_MSBF, MOP_MSIF, MOP_MSOF, MOP_FIRST:
        sel_result = first_result;
      MOP_CPOP:
        sel_result = pop_count;
      default:
        sel_result = '0;
    endcase
  end

  // kept bits come from the old destination
  assign merged = (sel_result & ~keep_mask) | (vd_data & keep_mask);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      result_data  <= '0;
    end else begin
      result_valid <= op_valid;
      // data holds across idle cycles
      if (op_valid)
        result_data <= merged;
    end
  end

endmodule

`default_nettype wire

// File: source/rvv_mask_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mask_top (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         uop_valid,
  input  rvv_mask_op_pkg::funct6_t     funct6,
  input  rvv_mask_op_pkg::funct3_t     funct3,
  input  rvv_mask_op_pkg::vs1_code_t   vs1_code,
  input  logic                         vm,
  input  rvv_mask_data_pkg::vl_t       vl,
  input  rvv_mask_data_pkg::vstart_t   vstart,
  input  rvv_mask_data_pkg::vreg_t     v0_data,
  input  rvv_mask_data_pkg::vreg_t     vs1_data,
  input  rvv_mask_data_pkg::vreg_t     vs2_data,
  input  rvv_mask_data_pkg::vreg_t     vd_data,
  input  logic                         v0_data_valid,
  input  logic                         vs1_data_valid,
  input  logic                         vs2_data_valid,
  input  logic                         vd_data_valid,
  output logic                         result_valid,
  output rvv_mask_data_pkg::vreg_t     result_data
);

  import rvv_mask_op_pkg::*;
  import rvv_mask_data_pkg::*;

  mask_op_e op;
  logic     op_valid;
  vreg_t    src1;
  vreg_t    src2;
  vreg_t    keep_mask;
  vreg_t    logic_result;
  vreg_t    first_result;
  vreg_t    pop_count;

  mask_uop_decode i_mask_uop_decode (
    .uop_valid, .funct6, .funct3, .vs1_code, .vm, .vl, .vstart,
    .v0_data, .vs1_data, .vs2_data,
    .v0_data_valid, .vs1_data_valid, .vs2_data_valid, .vd_data_valid,
    .op, .op_valid, .src1, .src2, .keep_mask
  );

  mask_logic_ops i_mask_logic_ops (
    .op, .src1, .src2, .logic_result
  );

  mask_set_first i_mask_set_first (
    .op, .src2, .first_result
  );

  mask_popcount i_mask_popcount (
    .src2, .pop_count
  );

  // one register stage on the way out
  mask_result_merge i_mask_result_merge (
    .clk, .arst_n, .op, .op_valid, .keep_mask, .vd_data,
    .logic_result, .first_result, .pop_count,
    .result_valid, .result_data
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tb/tb_rvv_mask.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_mask;

  import rvv_mask_op_pkg::*;
  import rvv_mask_data_pkg::*;

  localparam int MAX_TESTS = 32;
  localparam int WAIT_LIMIT = 10;

  typedef struct packed {
    funct6_t   funct6;
    funct3_t   funct3;
    vs1_code_t vs1_code;
    logic      vm;
    vl_t       vl;
    vstart_t   vstart;
    // v0, vs1, vs2, vd from high to low
    logic [3:0] valids;
    logic      exp_valid;
    vreg_t     v0;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     vd;
    vreg_t     exp_data;
  } entry_t;

  logic clk;
  logic arst_n;
  logic uop_valid;
  funct6_t funct6;
  funct3_t funct3;
  vs1_code_t vs1_code;
  logic vm;
  vl_t vl;
  vstart_t vstart;
  vreg_t v0_data;
  vreg_t vs1_data;
  vreg_t vs2_data;
  vreg_t vd_data;
  logic v0_data_valid;
  logic vs1_data_valid;
  logic vs2_data_valid;
  logic vd_data_valid;
  logic result_valid;
  vreg_t result_data;

  entry_t entries [MAX_TESTS];
  string names [MAX_TESTS];
  int num_tests = 0;
  int pass_count = 0;
  int fail_count = 0;
  logic cur_ok;
  logic [31:0] lcg_state = 32'd34509;

  tb_clock_gen i_tb_clock_gen (.clk);

  rvv_mask_top i_rvv_mask_top (
    .clk, .arst_n, .uop_valid, .funct6, .funct3, .vs1_code, .vm, .vl, .vstart,
    .v0_data, .vs1_data, .vs2_data, .vd_data,
    .v0_data_valid, .vs1_data_valid, .vs2_data_valid, .vd_data_valid,
    .result_valid, .result_data
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic vreg_t rand_vreg();
    vreg_t r;
    r = {lcg_next(), lcg_next()};
    return r;
  endfunction

  // expected result straight from the instruction rules, bit by bit
  function automatic vreg_t model_result(entry_t e);
    vreg_t r;
    vreg_t s;
    int first;
    int cnt;
    r = '0;
    first = -1;
    cnt = 0;
    if (e.funct6[5:3] == 3'b011) begin
      for (int i = 0; i < 64; i++) begin
        case (e.funct6[2:0])
          3'd0: r[i] = e.vs2[i] & ~e.vs1[i];
          3'd1: r[i] = e.vs2[i] & e.vs1[i];
          3'd2: r[i] = e.vs2[i] | e.vs1[i];
          3'd3: r[i] = e.vs2[i] ^ e.vs1[i];
          3'd4: r[i] = e.vs2[i] | ~e.vs1[i];
          3'd5: r[i] = ~(e.vs2[i] & e.vs1[i]);
          3'd6: r[i] = ~(e.vs2[i] | e.vs1[i]);
          default: r[i] = ~(e.vs2[i] ^ e.vs1[i]);
        endcase
        if (i < int'(e.vstart))
          r[i] = e.vd[i];
      end
    end else begin
      for (int i = 0; i < 64; i++) begin
        s[i] = e.vs2[i] & (e.vm | e.v0[i]);
        // vfirst and vcpop ignore the tail
        if (e.funct6 == 6'b010000 && i >= int'(e.vl))
          s[i] = 1'b0;
        if (s[i] && first < 0)
          first = i;
        if (s[i])
          cnt++;
      end
      for (int i = 0; i < 64; i++) begin
        case (e.vs1_code)
          5'b00001: r[i] = (first < 0) || (i < first);
          5'b00011: r[i] = (first < 0) || (i <= first);
          5'b00010: r[i] = (i == first);
          default: r[i] = 1'b0;
        endcase
        if (e.funct6 == 6'b010100 && !e.vm && !e.v0[i])
          r[i] = e.vd[i];
      end
      if (e.funct6 == 6'b010000)
        r = (e.vs1_code == 5'b10000) ? vreg_t'(cnt) : ((first < 0) ? '1 : vreg_t'(first));
    end
    return r;
  endfunction

  task automatic add_entry(string name, funct6_t f6, vs1_code_t v1c, logic m, vl_t len,
                           vstart_t start, logic [3:0] valids, logic exp_valid,
                           logic zero_src);
    entry_t e;
    e.funct6 = f6;
    e.funct3 = 3'b010;
    e.vs1_code = v1c;
    e.vm = m;
    e.vl = len;
    e.vstart = start;
    e.valids = valids;
    e.exp_valid = exp_valid;
    e.v0 = rand_vreg();
    e.vs1 = rand_vreg();
    e.vs2 = zero_src ? '0 : rand_vreg();
    e.vd = rand_vreg();
    e.exp_data = model_result(e);
    entries[num_tests] = e;
    names[num_tests] = name;
    num_tests++;
  endtask

  task automatic drive_entry(entry_t e);
    uop_valid = 1'b1;
    funct6 = e.funct6;
    funct3 = e.funct3;
    vs1_code = e.vs1_code;
    vm = e.vm;
    vl = e.vl;
    vstart = e.vstart;
    v0_data = e.v0;
    vs1_data = e.vs1;
    vs2_data = e.vs2;
    vd_data = e.vd;
    {v0_data_valid, vs1_data_valid, vs2_data_valid, vd_data_valid} = e.valids;
  endtask

  task automatic check_vreg(string name, vreg_t expected, vreg_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected %h actual %h", name, expected, actual);
      cur_ok = 1'b0;
    end
  endtask

  task automatic check_valid(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected valid %b actual valid %b", name, expected, actual);
      cur_ok = 1'b0;
    end
  endtask

  task automatic close_test(string name);
    if (cur_ok) begin
      $display("ok %s", name);
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  task automatic build_table();
    string lnames [8];
    lnames = '{"vmandn", "vmand", "vmor", "vmxor", "vmorn", "vmnand", "vmnor", "vmxnor"};
    for (int k = 0; k < 8; k++) begin
      add_entry(lnames[k], {3'b011, 3'(k)}, 5'd0, 1'b1, vl_t'(64),
                vstart_t'(lcg_next()), 4'b0111, 1'b1, 1'b0);
    end
    add_entry("vmsbf", 6'b010100, 5'b00001, 1'b1, vl_t'(64), '0, 4'b0010, 1'b1, 1'b0);
    add_entry("vmsif", 6'b010100, 5'b00011, 1'b1, vl_t'(64), '0, 4'b0010, 1'b1, 1'b0);
    add_entry("vmsof", 6'b010100, 5'b00010, 1'b1, vl_t'(64), '0, 4'b0010, 1'b1, 1'b0);
    add_entry("vmsbf_masked", 6'b010100, 5'b00001, 1'b0, vl_t'(64), '0, 4'b1011, 1'b1, 1'b0);
    add_entry("vmsif_masked", 6'b010100, 5'b00011, 1'b0, vl_t'(64), '0, 4'b1011, 1'b1, 1'b0);
    add_entry("vmsof_masked", 6'b010100, 5'b00010, 1'b0, vl_t'(64), '0, 4'b1011, 1'b1, 1'b0);
    add_entry("vmsbf_zero", 6'b010100, 5'b00001, 1'b1, vl_t'(64), '0, 4'b0010, 1'b1, 1'b1);
    add_entry("vmsif_zero", 6'b010100, 5'b00011, 1'b0, vl_t'(64), '0, 4'b1011, 1'b1, 1'b1);
    add_entry("vmsof_zero", 6'b010100, 5'b00010, 1'b1, vl_t'(64), '0, 4'b0010, 1'b1, 1'b1);
    add_entry("vfirst", 6'b010000, 5'b10001, 1'b1, vl_t'(lcg_next() % 65), '0,
              4'b0010, 1'b1, 1'b0);
    add_entry("vfirst_masked", 6'b010000, 5'b10001, 1'b0, vl_t'(lcg_next() % 65), '0,
              4'b1010, 1'b1, 1'b0);
    add_entry("vfirst_vl0", 6'b010000, 5'b10001, 1'b1, vl_t'(0), '0, 4'b0010, 1'b1, 1'b0);
    add_entry("vcpop", 6'b010000, 5'b10000, 1'b1, vl_t'(lcg_next() % 65), '0,
              4'b0010, 1'b1, 1'b0);
    add_entry("vcpop_masked", 6'b010000, 5'b10000, 1'b0, vl_t'(lcg_next() % 65), '0,
              4'b1010, 1'b1, 1'b0);
    // operand readiness cases that must produce no result
    add_entry("nrdy_vs2", 6'b011001, 5'd0, 1'b1, vl_t'(64), '0, 4'b0101, 1'b0, 1'b0);
    add_entry("nrdy_vs1_unary", 6'b010000, 5'b10001, 1'b1, vl_t'(64), '0, 4'b0110, 1'b0, 1'b0);
    add_entry("nrdy_vm_logic", 6'b011010, 5'd0, 1'b0, vl_t'(64), '0, 4'b1111, 1'b0, 1'b0);
    add_entry("nrdy_funct6", 6'b111111, 5'd0, 1'b1, vl_t'(64), '0, 4'b1111, 1'b0, 1'b0);
    add_entry("nrdy_vd_msbf", 6'b010100, 5'b00001, 1'b0, vl_t'(64), '0, 4'b1010, 1'b0, 1'b0);
  endtask

  initial begin
    int cycles;
    int prev;
    vreg_t held_data;
    arst_n = 1'b0;
    uop_valid = 1'b0;
    funct6 = '0;
    funct3 = '0;
    vs1_code = '0;
    vm = 1'b0;
    vl = '0;
    vstart = '0;
    v0_data = '0;
    vs1_data = '0;
    vs2_data = '0;
    vd_data = '0;
    {v0_data_valid, vs1_data_valid, vs2_data_valid, vd_data_valid} = 4'b0000;
    held_data = '0;
    build_table();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // outputs leave reset cleared
    cur_ok = 1'b1;
    check_valid("reset", 1'b0, result_valid);
    check_vreg("reset", '0, result_data);
    close_test("reset");

    for (int k = 0; k < num_tests; k++) begin
      cur_ok = 1'b1;
      drive_entry(entries[k]);
      @(negedge clk);
      uop_valid = 1'b0;
      if (!entries[k].exp_valid) begin
        check_valid(names[k], 1'b0, result_valid);
        check_vreg(names[k], held_data, result_data);
      end else begin
        cycles = 1;
        while (!result_valid && cycles < WAIT_LIMIT) begin
          @(negedge clk);
          cycles++;
        end
        if (!result_valid) begin
          $display("%s: no result arrived before the timeout", names[k]);
          cur_ok = 1'b0;
        end else begin
          if (cycles != 1) begin
            $display("%s: result arrived after %0d cycles instead of one", names[k], cycles);
            cur_ok = 1'b0;
          end
          check_vreg(names[k], entries[k].exp_data, result_data);
          held_data = entries[k].exp_data;
        end
      end
      // idle cycle drops valid and holds the data
      @(negedge clk);
      check_valid(names[k], 1'b0, result_valid);
      check_vreg(names[k], held_data, result_data);
      close_test(names[k]);
    end

    // back-to-back stream with each result checked one cycle after its micro-op
    prev = -1;
    for (int k = 0; k <= num_tests; k++) begin
      if (k < num_tests && !entries[k].exp_valid)
        continue;
      if (prev >= 0) begin
        cur_ok = 1'b1;
        check_valid({"b2b_", names[prev]}, 1'b1, result_valid);
        check_vreg({"b2b_", names[prev]}, entries[prev].exp_data, result_data);
        close_test({"b2b_", names[prev]});
      end
      if (k < num_tests) begin
        drive_entry(entries[k]);
        prev = k;
        @(negedge clk);
      end
    end
    uop_valid = 1'b0;

    $display("%0d checks passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #1ms;
    $display("simulation did not finish in time");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rvv_mask.f
+incdir+source
source/rvv_mask_op_pkg.sv
source/rvv_mask_data_pkg.sv
source/mask_uop_decode.sv
source/mask_logic_ops.sv
source/mask_set_first.sv
source/mask_popcount.sv
source/mask_result_merge.sv
source/rvv_mask_top.sv
tb/tb_clock_gen.sv
tb/tb_rvv_mask.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rvv_mask testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f rvv_mask.f --top-module tb_rvv_mask \
    -o sim_rvv_mask; then
  echo "compile failed"
  exit 1
fi

if ! output="$(./obj_dir/sim_rvv_mask)"; then
  printf '%s\n' "$output"
  echo "simulation exited with an error"
  exit 1
fi

printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
